/* backing_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module backing_mem #(
    parameter int mem_latency    = 3,
    parameter int mem_depth_bits = 10
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          mem_valid,
    input  wire                          mem_wr,
    input  wire  [cache_pkg::addr_w-1:0] mem_addr,
    input  wire  [cache_pkg::addr_w-1:0] mem_wdata,
    output logic                         mem_ready,
    output logic [cache_pkg::addr_w-1:0] mem_rdata
);
    import cache_pkg::*;

    localparam int depth = 1 << mem_depth_bits;
    localparam int cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;

    logic [addr_w-1:0]         mem [depth];
    logic                      busy;
    logic [cnt_w-1:0]          cnt;
    logic                      done;
    logic                      op_wr;
    logic [mem_depth_bits-1:0] op_idx;
    logic [addr_w-1:0]         op_wdata;

    initial
    begin
        for (int i = 0; i < depth; i++)
            mem[i] = '0;
    end

    assign done = busy && (cnt == cnt_w'(mem_latency - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            cnt       <= '0;
            mem_ready <= 1'b0;
        end
        else
        begin
            mem_ready <= done;
            if (!busy && mem_valid && !mem_ready)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (done)
                busy <= 1'b0;
            else if (busy)
                cnt <= cnt + 1'b1;
        end
    end

    // access latched on accept, performed on the last wait cycle.
    always @(posedge clk)
    begin
        if (!busy)
        begin
            op_wr    <= mem_wr;
            op_idx   <= mem_addr[off_w +: mem_depth_bits]; // word address, wraps.
            op_wdata <= mem_wdata;
        end
        if (done)
        begin
            if (op_wr)
                mem[op_idx] <= op_wdata;
            mem_rdata <= mem[op_idx];
        end
    end

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // address geometry shared by both caches.
    localparam int addr_w  = 32;
    localparam int off_w   = 2;
    localparam int index_w = 6;
    localparam int tag_w   = addr_w - index_w - off_w;

    // one byte address, taken whole or split for lookup.
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [off_w-1:0]   offset;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

/* cache_subsys.f */
cache_pkg.sv
icache.sv
dcache.sv
mem_arbiter.sv
backing_mem.sv
cache_subsys.sv
tb_cache_subsys.sv

/* cache_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_subsys #(
    parameter int mem_latency    = 3,
    parameter int mem_depth_bits = 10
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_req_valid,
    input  wire  [cache_pkg::addr_w-1:0] i_req_addr,
    output logic                         i_resp_valid,
    output logic [cache_pkg::addr_w-1:0] i_resp_data,
    input  wire                          d_req_valid,
    input  wire                          d_req_wr,
    input  wire  [cache_pkg::addr_w-1:0] d_req_addr,
    input  wire  [cache_pkg::addr_w-1:0] d_wr_data,
    output logic                         d_resp_valid,
    output logic [cache_pkg::addr_w-1:0] d_resp_data
);
    import cache_pkg::*;

    // cache side of the arbiter.
    logic              i_mem_valid;
    logic [addr_w-1:0] i_mem_addr;
    logic              i_mem_ready;
    logic [addr_w-1:0] i_mem_rdata;
    logic              d_mem_valid;
    logic              d_mem_wr;
    logic [addr_w-1:0] d_mem_addr;
    logic [addr_w-1:0] d_mem_wdata;
    logic              d_mem_ready;
    logic [addr_w-1:0] d_mem_rdata;

    // memory side.
    logic              mem_valid;
    logic              mem_wr;
    logic [addr_w-1:0] mem_addr;
    logic [addr_w-1:0] mem_wdata;
    logic              mem_ready;
    logic [addr_w-1:0] mem_rdata;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (i_req_valid),
        .req_addr   (i_req_addr),
        .resp_valid (i_resp_valid),
        .resp_data  (i_resp_data),
        .mem_valid  (i_mem_valid),
        .mem_addr   (i_mem_addr),
        .mem_ready  (i_mem_ready),
        .mem_rdata  (i_mem_rdata)
    );

    dcache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (d_req_valid),
        .req_wr     (d_req_wr),
        .req_addr   (d_req_addr),
        .wr_data    (d_wr_data),
        .resp_valid (d_resp_valid),
        .resp_data  (d_resp_data),
        .mem_valid  (d_mem_valid),
        .mem_wr     (d_mem_wr),
        .mem_addr   (d_mem_addr),
        .mem_wdata  (d_mem_wdata),
        .mem_ready  (d_mem_ready),
        .mem_rdata  (d_mem_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_mem_valid (i_mem_valid),
        .i_mem_addr  (i_mem_addr),
        .i_mem_ready (i_mem_ready),
        .i_mem_rdata (i_mem_rdata),
        .d_mem_valid (d_mem_valid),
        .d_mem_wr    (d_mem_wr),
        .d_mem_addr  (d_mem_addr),
        .d_mem_wdata (d_mem_wdata),
        .d_mem_ready (d_mem_ready),
        .d_mem_rdata (d_mem_rdata),
        .mem_valid   (mem_valid),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

    backing_mem #(
        .mem_latency    (mem_latency),
        .mem_depth_bits (mem_depth_bits)
    ) u_backing_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req_valid,
    input  wire                          req_wr,
    input  wire  [cache_pkg::addr_w-1:0] req_addr,
    input  wire  [cache_pkg::addr_w-1:0] wr_data,
    output logic                         resp_valid,
    output logic [cache_pkg::addr_w-1:0] resp_data,
    output logic                         mem_valid,
    output logic                         mem_wr,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    output logic [cache_pkg::addr_w-1:0] mem_wdata,
    input  wire                          mem_ready,
    input  wire  [cache_pkg::addr_w-1:0] mem_rdata
);
    import cache_pkg::*;

    localparam int lines = 1 << index_w;

    localparam logic [2:0] idle       = 3'd0;
    localparam logic [2:0] lookup     = 3'd1;
    localparam logic [2:0] write_back = 3'd2;
    localparam logic [2:0] fill       = 3'd3;
    localparam logic [2:0] respond    = 3'd4;

    logic [2:0]         state;
    cache_addr_u        addr_q;
    cache_addr_u        fill_a;
    cache_addr_u        victim_a;
    logic               wr_q;
    logic [addr_w-1:0]  wdata_q;
    logic [lines-1:0]   valid_q;
    logic [lines-1:0]   dirty_q;
    logic [tag_w-1:0]   tag_mem [lines];
    logic [addr_w-1:0]  data_mem [lines];
    logic [index_w-1:0] idx;
    logic               hit;
    logic               victim_dirty;
    logic               mem_done;
    logic               install_wr;
    logic               fill_done;

    assign idx          = addr_q.fields.index;
    assign hit          = valid_q[idx] && (tag_mem[idx] == addr_q.fields.tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];
    assign mem_done     = mem_valid && mem_ready;
    assign fill_done    = (state == fill) && mem_done;

    // write hit, clean write miss, or write miss once the victim is out.
    assign install_wr = wr_q && (((state == lookup) && (hit || !victim_dirty))
                                 || ((state == write_back) && mem_done));

    always_comb
    begin
        fill_a.fields.tag      = addr_q.fields.tag;
        fill_a.fields.index    = idx;
        fill_a.fields.offset   = '0;
        victim_a.fields.tag    = tag_mem[idx]; // rebuilt from the stored line.
        victim_a.fields.index  = idx;
        victim_a.fields.offset = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle;
            resp_valid <= 1'b0;
            mem_valid  <= 1'b0;
            mem_wr     <= 1'b0;
            valid_q    <= '0;
            dirty_q    <= '0;
        end
        else
        begin
            resp_valid <= 1'b0;
            if (install_wr)
            begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b1;
            end
            case (state)
                idle:
                begin
                    if (req_valid && !resp_valid)
                        state <= lookup;
                end
                lookup:
                begin
                    if (hit || (wr_q && !victim_dirty))
                        state <= respond;
                    else if (victim_dirty)
                        state <= write_back;
                    else
                        state <= fill;
                end
                write_back:
                begin
                    if (!mem_valid)
                    begin
                        mem_valid <= 1'b1;
                        mem_wr    <= 1'b1;
                    end
                    else if (mem_ready)
                    begin
                        mem_valid <= 1'b0;
                        mem_wr    <= 1'b0;
                        if (wr_q)
                            state <= respond;
                        else
                        begin
                            dirty_q[idx] <= 1'b0; // memory now holds it.
                            state        <= fill;
                        end
                    end
                end
                fill:
                begin
                    if (!mem_valid)
                        mem_valid <= 1'b1;
                    else if (mem_ready)
                    begin
                        mem_valid    <= 1'b0;
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                        state        <= respond;
                    end
                end
                respond:
                begin
                    resp_valid <= 1'b1;
                    state      <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle)
        begin
            addr_q.raw <= req_addr;
            wr_q       <= req_wr;
            wdata_q    <= wr_data;
        end
        if (state == lookup && hit)
            resp_data <= data_mem[idx];
        if (state == write_back && !mem_valid)
        begin
            mem_addr  <= victim_a.raw;
            mem_wdata <= data_mem[idx];
        end
        if (state == fill && !mem_valid)
            mem_addr <= fill_a.raw;
        if (install_wr)
        begin
            tag_mem[idx]  <= addr_q.fields.tag;
            data_mem[idx] <= wdata_q;
        end
        if (fill_done)
        begin
            tag_mem[idx]  <= addr_q.fields.tag;
            data_mem[idx] <= mem_rdata;
            resp_data     <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* icache.sv */
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req_valid,
    input  wire  [cache_pkg::addr_w-1:0] req_addr,
    output logic                         resp_valid,
    output logic [cache_pkg::addr_w-1:0] resp_data,
    output logic                         mem_valid,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    input  wire                          mem_ready,
    input  wire  [cache_pkg::addr_w-1:0] mem_rdata
);
    import cache_pkg::*;

    localparam int lines = 1 << index_w;

    localparam logic [1:0] idle    = 2'd0;
    localparam logic [1:0] lookup  = 2'd1;
    localparam logic [1:0] fill    = 2'd2;
    localparam logic [1:0] respond = 2'd3;

    logic [1:0]        state;
    cache_addr_u       addr_q;
    cache_addr_u       fill_a;
    logic [lines-1:0]  valid_q;
    logic [tag_w-1:0]  tag_mem [lines];
    logic [addr_w-1:0] data_mem [lines];
    logic              hit;
    logic              fill_done;

    assign hit = valid_q[addr_q.fields.index]
                 && (tag_mem[addr_q.fields.index] == addr_q.fields.tag);

    assign fill_done = (state == fill) && mem_valid && mem_ready;

    // word-aligned read address for the missing line.
    always_comb
    begin
        fill_a.fields.tag    = addr_q.fields.tag;
        fill_a.fields.index  = addr_q.fields.index;
        fill_a.fields.offset = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle;
            resp_valid <= 1'b0;
            mem_valid  <= 1'b0;
            valid_q    <= '0;
        end
        else
        begin
            resp_valid <= 1'b0;
            case (state)
                idle:
                begin
                    // old request still up during the response pulse.
                    if (req_valid && !resp_valid)
                        state <= lookup;
                end
                lookup:
                begin
                    if (hit)
                        state <= respond;
                    else
                        state <= fill;
                end
                fill:
                begin
                    if (!mem_valid)
                        mem_valid <= 1'b1;
                    else if (mem_ready)
                    begin
                        mem_valid                      <= 1'b0;
                        valid_q[addr_q.fields.index]   <= 1'b1;
                        state                          <= respond;
                    end
                end
                respond:
                begin
                    resp_valid <= 1'b1;
                    state      <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle)
            addr_q.raw <= req_addr;
        if (state == lookup && hit)
            resp_data <= data_mem[addr_q.fields.index];
        if (state == fill && !mem_valid)
            mem_addr <= fill_a.raw;
        if (fill_done)
        begin
            tag_mem[addr_q.fields.index]  <= addr_q.fields.tag;
            data_mem[addr_q.fields.index] <= mem_rdata;
            resp_data                     <= mem_rdata; // forward the fill.
        end
    end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_mem_valid,
    input  wire  [cache_pkg::addr_w-1:0] i_mem_addr,
    output logic                         i_mem_ready,
    output logic [cache_pkg::addr_w-1:0] i_mem_rdata,
    input  wire                          d_mem_valid,
    input  wire                          d_mem_wr,
    input  wire  [cache_pkg::addr_w-1:0] d_mem_addr,
    input  wire  [cache_pkg::addr_w-1:0] d_mem_wdata,
    output logic                         d_mem_ready,
    output logic [cache_pkg::addr_w-1:0] d_mem_rdata,
    output logic                         mem_valid,
    output logic                         mem_wr,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    output logic [cache_pkg::addr_w-1:0] mem_wdata,
    input  wire                          mem_ready,
    input  wire  [cache_pkg::addr_w-1:0] mem_rdata
);
    logic busy;
    logic owner_d;   // grant holder, 1 is the data side.
    logic last_d;
    logic pick_d;

    // on a tie the side not granted last wins.
    assign pick_d = d_mem_valid && (!i_mem_valid || !last_d);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
            last_d  <= 1'b0;
        end
        else if (!busy)
        begin
            if (i_mem_valid || d_mem_valid)
            begin
                busy    <= 1'b1;
                owner_d <= pick_d;
                last_d  <= pick_d;
            end
        end
        else if (mem_ready)
            busy <= 1'b0; // released on the ready edge.
    end

    assign mem_valid = busy && (owner_d ? d_mem_valid : i_mem_valid);
    assign mem_wr    = busy && owner_d && d_mem_wr; // icache only reads.
    assign mem_addr  = owner_d ? d_mem_addr : i_mem_addr;
    assign mem_wdata = owner_d ? d_mem_wdata : '0;

    assign i_mem_ready = busy && !owner_d && mem_ready;
    assign d_mem_ready = busy && owner_d && mem_ready;
    assign i_mem_rdata = owner_d ? '0 : mem_rdata;
    assign d_mem_rdata = owner_d ? mem_rdata : '0;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the cache subsystem testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache_subsys \
    -f cache_subsys.f > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/Vtb_cache_subsys > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

# the log decides the result.
grep -q "Test failures found" sim.log && exit 1 || exit 0

/* tb_cache_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cache_subsys;
    import cache_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int iterations     = 40;

    logic              clk;
    logic              rst;
    logic              i_req_valid;
    logic [addr_w-1:0] i_req_addr;
    logic              i_resp_valid;
    logic [addr_w-1:0] i_resp_data;
    logic              d_req_valid;
    logic              d_req_wr;
    logic [addr_w-1:0] d_req_addr;
    logic [addr_w-1:0] d_wr_data;
    logic              d_resp_valid;
    logic [addr_w-1:0] d_resp_data;

    // word models below 4 KB, data side and what memory holds for the icache.
    logic [addr_w-1:0] dmodel [1024];
    logic [addr_w-1:0] imodel [1024];
    logic [tag_w-1:0]  dir_tag [64];
    logic [63:0]       dir_valid;
    logic [63:0]       dir_dirty;
    logic [addr_w-1:0] flushed [$];

    int seed = 61;
    int n_pass;
    int n_fail;

    cache_subsys i_cache_subsys (
        .clk          (clk),
        .rst          (rst),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_resp_valid (i_resp_valid),
        .i_resp_data  (i_resp_data),
        .d_req_valid  (d_req_valid),
        .d_req_wr     (d_req_wr),
        .d_req_addr   (d_req_addr),
        .d_wr_data    (d_wr_data),
        .d_resp_valid (d_resp_valid),
        .d_resp_data  (d_resp_data)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [addr_w-1:0] expected,
                               input logic [addr_w-1:0] actual);
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            n_fail++;
        end
        if (actual === expected)
            n_pass++;
    endtask

    // direct-mapped write-back directory; a dirty victim goes out to memory.
    task automatic model_access(input logic wr, input logic [addr_w-1:0] addr,
                                input logic [addr_w-1:0] data);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        logic [9:0]         victim;
        idx = addr[off_w +: index_w];
        tag = addr[addr_w-1 -: tag_w];
        if (!(dir_valid[idx] && dir_tag[idx] == tag))
        begin
            if (dir_valid[idx] && dir_dirty[idx])
            begin
                victim         = {dir_tag[idx][3:0], idx};
                imodel[victim] = dmodel[victim];
                flushed.push_back({20'd0, victim, 2'b00});
            end
            dir_valid[idx] = 1'b1;
            dir_tag[idx]   = tag;
            dir_dirty[idx] = 1'b0;
        end
        if (wr)
        begin
            dir_dirty[idx]     = 1'b1;
            dmodel[addr[11:2]] = data;
        end
    endtask

    task automatic dcache_req(input logic wr, input logic [addr_w-1:0] addr,
                              input logic [addr_w-1:0] data,
                              output logic [addr_w-1:0] rdata, output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        d_req_valid <= 1'b1;
        d_req_wr    <= wr;
        d_req_addr  <= addr;
        d_wr_data   <= data;
        while (!done && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
            done = (d_resp_valid === 1'b1);
        end
        rdata = d_resp_data;
        if (!done)
        begin
            $display("dcache request to %h got no response in %0d cycles", addr,
                     timeout_cycles);
            n_fail++;
        end
        @(posedge clk);
        d_req_valid <= 1'b0; // resp_valid cycle, so the cache ignores the old request.
    endtask

    task automatic icache_req(input logic [addr_w-1:0] addr, output logic [addr_w-1:0] rdata);
        logic done;
        int   cycles;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        i_req_valid <= 1'b1;
        i_req_addr  <= addr;
        while (!done && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
            done = (i_resp_valid === 1'b1);
        end
        rdata = i_resp_data;
        if (!done)
        begin
            $display("icache request to %h got no response in %0d cycles", addr,
                     timeout_cycles);
            n_fail++;
        end
        @(posedge clk);
        i_req_valid <= 1'b0;
    endtask

    task automatic dcache_op(input string name, input logic wr, input logic [addr_w-1:0] addr,
                             input logic [addr_w-1:0] data, output int cycles);
        logic [addr_w-1:0] expected;
        logic [addr_w-1:0] rdata;
        expected = dmodel[addr[11:2]];
        dcache_req(wr, addr, data, rdata, cycles);
        model_access(wr, addr, data);
        if (!wr)
            check_value(name, expected, rdata);
    endtask

    task automatic icache_op(input string name, input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] expected;
        logic [addr_w-1:0] rdata;
        expected = imodel[addr[11:2]];
        icache_req(addr, rdata);
        check_value(name, expected, rdata);
    endtask

    task automatic finish_test(input string name, input int fails_before);
        if (n_fail == fails_before)
            $display("test %s: ok", name);
        else
            $display("test %s: FAILED with %0d errors", name, n_fail - fails_before);
    endtask

    initial
    begin
        logic [addr_w-1:0] data_a;
        logic [addr_w-1:0] data_b;
        logic [addr_w-1:0] r;
        logic [addr_w-1:0] i_addrs [iterations];
        logic [addr_w-1:0] d_addrs [iterations];
        logic [addr_w-1:0] d_datas [iterations];
        logic              d_wrs [iterations];
        int                cycles;
        int                fails;
        int                pick;
        clk         = 1'b0;
        rst         = 1'b1;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        d_req_valid = 1'b0;
        d_req_wr    = 1'b0;
        d_req_addr  = '0;
        d_wr_data   = '0;
        n_pass      = 0;
        n_fail      = 0;
        dir_valid   = '0;
        dir_dirty   = '0;
        for (int i = 0; i < 1024; i++)
        begin
            dmodel[i] = '0;
            imodel[i] = '0;
        end

        fails = n_fail;
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            if (i == 3)
                rst <= 1'b0;
            @(negedge clk);
            check_value("reset", '0, addr_w'(i_resp_valid));
            check_value("reset", '0, addr_w'(d_resp_valid));
        end
        @(negedge clk);
        check_value("reset", '0, addr_w'(i_resp_valid));
        check_value("reset", '0, addr_w'(d_resp_valid));
        finish_test("reset", fails);

        fails  = n_fail;
        data_a = $random(seed);
        dcache_op("read_after_write", 1'b1, 32'h040, data_a, cycles);
        dcache_op("read_after_write", 1'b0, 32'h040, '0, cycles);
        // first negedge comes before the sampling edge.
        check_value("hit_latency", 2, addr_w'(cycles - 2));
        finish_test("read_after_write", fails);

        fails  = n_fail;
        data_a = $random(seed);
        data_b = $random(seed);
        dcache_op("dirty_evict", 1'b1, 32'h100, data_a, cycles);
        dcache_op("dirty_evict", 1'b1, 32'h200, data_b, cycles); // same index, new tag.
        dcache_op("dirty_evict", 1'b0, 32'h100, '0, cycles);
        dcache_op("dirty_evict", 1'b0, 32'h200, '0, cycles);
        finish_test("dirty_evict", fails);

        fails = n_fail;
        icache_op("ifetch", 32'h300);
        icache_op("ifetch", 32'h300);
        icache_op("ifetch", 32'h100);
        finish_test("ifetch", fails);

        // icache stays on stable words, dcache works in its own region.
        for (int i = 0; i < iterations; i++)
        begin
            r    = $random(seed);
            pick = int'(r[7:1]) % flushed.size();
            if (r[0])
                i_addrs[i] = flushed[pick];
            else
                i_addrs[i] = 32'h400 | (r & 32'h3fc);
            r          = $random(seed);
            d_wrs[i]   = r[0];
            d_addrs[i] = 32'h800 | (r & 32'h3fc);
            d_datas[i] = $random(seed);
        end
        fails = n_fail;
        fork
            begin
                for (int i = 0; i < iterations; i++)
                    icache_op("concurrent", i_addrs[i]);
            end
            begin
                for (int j = 0; j < iterations; j++)
                    dcache_op("concurrent", d_wrs[j], d_addrs[j], d_datas[j], cycles);
            end
        join
        finish_test("concurrent", fails);

        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
